//--- src/bpc_pkg.sv
/*
 * bad-pixel checker shared definitions
 * coordinate widths, table geometry, window size and bus structs
 */
package bpc_pkg;

    // ============================================================
    // geometry
    // ============================================================
    localparam int X_BITS      = 10;   // x coordinate width
    localparam int Y_BITS      = 10;   // y coordinate width
    localparam int TABLE_DEPTH = 128;  // bad-pixel table entries
    localparam int INDEX_BITS  = 7;    // table address / entry count
    localparam int WIN_RADIUS  = 2;    // 5x5 window -> +-2

    typedef logic [X_BITS-1:0] coord_x_t;
    typedef logic [Y_BITS-1:0] coord_y_t;

    // ============================================================
    // packed buses
    // ============================================================

    // stream position, y in the upper half
    typedef struct packed {
        coord_y_t y;
        coord_x_t x;
    } pixel_pos_t;

    // one table entry, same layout as the position
    typedef struct packed {
        coord_y_t y;
        coord_x_t x;
    } bad_coord_t;

    // software write strobe
    typedef struct packed {
        logic                  en;     // one cycle per write
        logic [INDEX_BITS-1:0] addr;
        bad_coord_t            coord;
    } table_wr_t;

    // one cached x-interval, both ends inclusive
    typedef struct packed {
        coord_x_t x_end;
        coord_x_t x_start;
    } region_t;

endpackage

//--- src/coord_table.sv
/*
 * bad-pixel coordinate table
 * software-written memory with one synchronous read port, plus the entry count
 */
`timescale 1ns/1ns

module coord_table (
    input  logic                           S_AXI_ACLK,
    input  logic                           rst_n,
    input  bpc_pkg::table_wr_t             table_wr,
    input  logic [bpc_pkg::INDEX_BITS-1:0] bad_point_num,
    input  logic [bpc_pkg::INDEX_BITS-1:0] rd_addr,
    output bpc_pkg::bad_coord_t            rd_data,
    output logic [bpc_pkg::INDEX_BITS-1:0] entry_count
);
    import bpc_pkg::*;

    // ============================================================
    // coordinate storage
    // ============================================================
    bad_coord_t mem [TABLE_DEPTH];  // maps onto a simple dual-port RAM

    // write side, one entry per strobe
    always_ff @(posedge S_AXI_ACLK) begin
        if (table_wr.en) begin
            mem[table_wr.addr] <= table_wr.coord;
        end
    end

    // read side, data one cycle after the address
    always_ff @(posedge S_AXI_ACLK) begin
        rd_data <= mem[rd_addr];
    end

    // ============================================================
    // valid-entry count
    // ============================================================

    // software holds this stable while a frame runs
    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            entry_count <= '0;          // empty table until programmed
        end else begin
            entry_count <= bad_point_num;
        end
    end

endmodule

//--- src/line_cache_builder.sv
/*
 * line cache builder
 * scans the bad-pixel table once per row, collects the x-intervals of the
 * windows covering the target row and swaps them into the active cache
 */
`timescale 1ns/1ns

module line_cache_builder #(
    parameter int IMAGE_WIDTH  = 640,
    parameter int IMAGE_HEIGHT = 512,
    parameter int MAX_REGIONS  = 16
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                rst_n,
    input  logic                                frame_start,
    input  bpc_pkg::pixel_pos_t                 pos,
    input  logic [bpc_pkg::INDEX_BITS-1:0]      entry_count,
    output logic [bpc_pkg::INDEX_BITS-1:0]      rd_addr,
    input  bpc_pkg::bad_coord_t                 rd_data,
    output bpc_pkg::region_t [MAX_REGIONS-1:0]  active_regions,
    output logic [$clog2(MAX_REGIONS+1)-1:0]    region_count,
    output logic                                cache_valid
);
    import bpc_pkg::*;

    localparam int CNT_BITS = $clog2(MAX_REGIONS+1);
    localparam logic [Y_BITS:0] RAD_Y = (Y_BITS+1)'(WIN_RADIUS);
    localparam logic [X_BITS:0] RAD_X = (X_BITS+1)'(WIN_RADIUS);

    typedef enum logic [2:0] {
        ST_IDLE,    // waiting for the first frame
        ST_SCAN,    // address phase of one entry
        ST_READ,    // data phase, append if the window hits
        ST_SWAP,    // next cache -> active cache
        ST_RUN      // matching, watching for row ends
    } state_t;

    state_t                         state;
    logic [INDEX_BITS-1:0]          scan_addr;     // entry being scanned
    coord_y_t                       target_row;    // row under build / last built
    region_t [MAX_REGIONS-1:0]      next_regions;  // cache being filled
    logic [CNT_BITS-1:0]            next_count;

    logic [Y_BITS:0]                y_lo;          // one extra bit, no wrap
    logic [Y_BITS:0]                y_hi;
    logic [X_BITS:0]                x_hi_w;
    coord_x_t                       x_lo;
    coord_x_t                       x_hi;
    logic                           row_hit;       // entry window covers target_row
    logic                           has_room;
    region_t                        new_region;
    logic [Y_BITS:0]                next_row;
    logic                           row_trigger;

    // ============================================================
    // window of the entry on rd_data
    // ============================================================
    always_comb begin
        y_lo = (rd_data.y >= RAD_Y[Y_BITS-1:0]) ? {1'b0, rd_data.y} - RAD_Y : '0;
        y_hi = {1'b0, rd_data.y} + RAD_Y;
        x_lo = (rd_data.x >= RAD_X[X_BITS-1:0]) ? rd_data.x - RAD_X[X_BITS-1:0] : '0;
        x_hi_w = {1'b0, rd_data.x} + RAD_X;
        x_hi = x_hi_w[X_BITS] ? '1 : x_hi_w[X_BITS-1:0];  // saturate at the top

        row_hit = ({1'b0, target_row} >= y_lo) && ({1'b0, target_row} <= y_hi);
        has_room = (next_count < CNT_BITS'(MAX_REGIONS));  // later windows dropped
        new_region.x_start = x_lo;
        new_region.x_end   = x_hi;
    end

    // once per row: last column seen and the next row not yet built
    always_comb begin
        next_row = {1'b0, pos.y} + 1'b1;
        row_trigger = (pos.x == X_BITS'(IMAGE_WIDTH - 1))
                   && (next_row < (Y_BITS+1)'(IMAGE_HEIGHT))
                   && (next_row[Y_BITS-1:0] != target_row);
    end

    assign rd_addr = scan_addr;  // registered address straight to the RAM

    // ============================================================
    // control FSM
    // ============================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            scan_addr    <= '0;
            target_row   <= '0;
            next_count   <= '0;
            region_count <= '0;
            cache_valid  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_start) begin
                        target_row  <= '0;          // row 0 first
                        scan_addr   <= '0;
                        next_count  <= '0;
                        cache_valid <= 1'b0;
                        state       <= ST_SCAN;
                    end
                end

                ST_SCAN: begin
                    if (scan_addr < entry_count) begin
                        state <= ST_READ;           // rd_data valid next cycle
                    end else begin
                        state <= ST_SWAP;           // table exhausted
                    end
                end

                ST_READ: begin
                    scan_addr <= scan_addr + 1'b1;
                    if (row_hit && has_room) begin
                        next_count <= next_count + 1'b1;
                    end
                    state <= ST_SCAN;
                end

                ST_SWAP: begin
                    region_count <= next_count;
                    cache_valid  <= 1'b1;
                    state        <= ST_RUN;
                end

                ST_RUN: begin
                    if (frame_start) begin
                        // restart, old frame's cache no longer meaningful
                        target_row  <= '0;
                        scan_addr   <= '0;
                        next_count  <= '0;
                        cache_valid <= 1'b0;
                        state       <= ST_SCAN;
                    end else if (row_trigger) begin
                        target_row <= next_row[Y_BITS-1:0];
                        scan_addr  <= '0;
                        next_count <= '0;
                        state      <= ST_SCAN;  // old cache stays active
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ============================================================
    // interval storage
    // ============================================================
    always_ff @(posedge S_AXI_ACLK) begin
        if (state == ST_READ && row_hit && has_room) begin
            next_regions[next_count] <= new_region;
        end
        if (state == ST_SWAP) begin
            active_regions <= next_regions;  // whole list at once
        end
    end

endmodule

//--- src/region_matcher.sv
/*
 * region matcher
 * parallel compare of the stream x against every cached interval
 */
`timescale 1ns/1ns

module region_matcher #(
    parameter int MAX_REGIONS = 16
) (
    input  bpc_pkg::coord_x_t                   x,
    input  bpc_pkg::region_t [MAX_REGIONS-1:0]  active_regions,
    input  logic [$clog2(MAX_REGIONS+1)-1:0]    region_count,
    input  logic                                cache_valid,
    output logic                                match
);
    localparam int CNT_BITS = $clog2(MAX_REGIONS+1);

    logic [MAX_REGIONS-1:0] slot_used;   // slot below region_count
    logic [MAX_REGIONS-1:0] slot_hit;    // x inside the slot's interval

    // ============================================================
    // per-slot compare
    // ============================================================
    genvar i;
    generate
        for (i = 0; i < MAX_REGIONS; i++) begin : g_slot
            assign slot_used[i] = (CNT_BITS'(i) < region_count);
            assign slot_hit[i]  = slot_used[i]
                               && (x >= active_regions[i].x_start)
                               && (x <= active_regions[i].x_end);
        end
    endgenerate

    // stale slots above the count are masked out above,
    // nothing matches before the first swap of a frame
    assign match = cache_valid & (|slot_hit);

endmodule

//--- src/bad_pixel_checker.sv
/*
 * bad-pixel region checker, top level
 * coordinate table, per-row cache builder and combinational matcher
 */
`timescale 1ns/1ns

module bad_pixel_checker #(
    parameter int IMAGE_WIDTH  = 640,
    parameter int IMAGE_HEIGHT = 512,
    parameter int MAX_REGIONS  = 16
) (
    input  logic                           S_AXI_ACLK,
    input  logic                           rst_n,
    input  bpc_pkg::table_wr_t             table_wr,      // software write port
    input  logic [bpc_pkg::INDEX_BITS-1:0] bad_point_num, // valid entries
    input  logic                           frame_start,   // SOF pulse
    input  bpc_pkg::pixel_pos_t            pos,           // current pixel
    output logic                           bad_pixel_match
);
    import bpc_pkg::*;

    // ============================================================
    // internal wiring
    // ============================================================
    logic [INDEX_BITS-1:0]              rd_addr;
    bad_coord_t                         rd_data;
    logic [INDEX_BITS-1:0]              entry_count;
    region_t [MAX_REGIONS-1:0]          active_regions;
    logic [$clog2(MAX_REGIONS+1)-1:0]   region_count;
    logic                               cache_valid;

    // configuration block
    coord_table u_table (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .rst_n         (rst_n),
        .table_wr      (table_wr),
        .bad_point_num (bad_point_num),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .entry_count   (entry_count)
    );

    // row cache, one build per row
    line_cache_builder #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .MAX_REGIONS  (MAX_REGIONS)
    ) u_builder (
        .S_AXI_ACLK     (S_AXI_ACLK),
        .rst_n          (rst_n),
        .frame_start    (frame_start),
        .pos            (pos),
        .entry_count    (entry_count),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .active_regions (active_regions),
        .region_count   (region_count),
        .cache_valid    (cache_valid)
    );

    // zero-latency match on the live x
    region_matcher #(
        .MAX_REGIONS (MAX_REGIONS)
    ) u_matcher (
        .x              (pos.x),
        .active_regions (active_regions),
        .region_count   (region_count),
        .cache_valid    (cache_valid),
        .match          (bad_pixel_match)
    );

endmodule

//--- test/bpc_chk.sv
/*
 * builder property checks, bound into line_cache_builder
 */
`timescale 1ns/1ns

module bpc_chk #(
    parameter int MAX_REGIONS = 16
) (
    input  logic                                S_AXI_ACLK,
    input  logic                                rst_n,
    input  logic                                cache_valid,
    input  logic [$clog2(MAX_REGIONS+1)-1:0]    region_count,
    input  logic [bpc_pkg::INDEX_BITS-1:0]      rd_addr,
    input  logic [bpc_pkg::INDEX_BITS-1:0]      entry_count,
    input  logic                                scan_read     // builder in its data phase
);
    int unsigned fail_count = 0;  // read by the testbench at the end

    // reset clears the cache flag by the next edge
    a_valid_in_reset: assert property (@(posedge S_AXI_ACLK) !rst_n |=> !cache_valid)
        else begin
            $error("cache_valid high while reset is applied");
            fail_count++;
        end

    // never more intervals than slots
    a_count_limit: assert property (@(posedge S_AXI_ACLK) disable iff (!rst_n)
        region_count <= MAX_REGIONS)
        else begin
            $error("region_count above MAX_REGIONS");
            fail_count++;
        end

    // data phase only for entries inside the valid range
    a_addr_range: assert property (@(posedge S_AXI_ACLK) disable iff (!rst_n)
        scan_read |-> (rd_addr < entry_count))
        else begin
            $error("rd_addr reached entry_count during a scan");
            fail_count++;
        end

endmodule

//--- test/bpc_scoreboard.sv
/*
 * bad-pixel checker scoreboard
 * shadows the table writes and compares bad_pixel_match with a reference
 */
`timescale 1ns/1ns

module bpc_scoreboard #(
    parameter int MAX_REGIONS = 16
) (
    input  logic                           S_AXI_ACLK,
    input  logic                           rst_n,
    input  bpc_pkg::table_wr_t             table_wr,
    input  logic [bpc_pkg::INDEX_BITS-1:0] bad_point_num,
    input  logic                           frame_start,
    input  bpc_pkg::pixel_pos_t            pos,
    input  logic                           pixel_valid,    // streamed pixel, not blanking
    input  logic                           bad_pixel_match,
    output int                             check_count,
    output int                             error_count
);
    import bpc_pkg::*;

    bad_coord_t shadow [TABLE_DEPTH];  // copy of what software wrote
    int         frame_count = 0;      // valid entries of the running frame
    logic       frame_seen;           // a frame has started since reset
    logic       expected_match;
    int         checks = 0;
    int         errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // ============================================================
    // table and frame tracking
    // ============================================================
    always @(posedge S_AXI_ACLK) begin
        if (table_wr.en) begin
            shadow[table_wr.addr] <= table_wr.coord;
        end
        if (!rst_n) begin
            frame_seen <= 1'b0;
        end else if (frame_start) begin
            frame_seen  <= 1'b1;
            frame_count <= int'(bad_point_num);   // count latched per frame
        end
    end

    // pixel inside the clipped 5x5 window of one of the first
    // MAX_REGIONS entries whose rows cover py
    function automatic logic ref_match(input int px, input int py);
        int   i;
        int   used;
        int   ex;
        int   ey;
        logic hit;
        used = 0;
        hit  = 1'b0;
        for (i = 0; i < frame_count; i++) begin
            ex = int'(shadow[i].x);
            ey = int'(shadow[i].y);
            if (py >= ((ey >= WIN_RADIUS) ? ey - WIN_RADIUS : 0) &&
                py <= ey + WIN_RADIUS && used < MAX_REGIONS) begin
                used++;                                     // slot taken
                if (px >= ((ex >= WIN_RADIUS) ? ex - WIN_RADIUS : 0) &&
                    px <= ex + WIN_RADIUS) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // ============================================================
    // compare, mid-cycle where pos and the cache are settled
    // ============================================================
    always @(negedge S_AXI_ACLK) begin
        if (rst_n && pixel_valid) begin
            expected_match = frame_seen ? ref_match(int'(pos.x), int'(pos.y)) : 1'b0;
            checks++;
            if (bad_pixel_match !== expected_match) begin
                errors++;
                $display("Error at %0t ns: x=%0d y=%0d expected %0b actual %0b",
                         $time, pos.x, pos.y, expected_match, bad_pixel_match);
            end
        end
    end

endmodule

//--- test/tb_bad_pixel_checker.sv
/*
 * bad-pixel checker testbench
 * programs the table, streams frames and reports the scoreboard result
 */
`timescale 1ns/1ns

module tb_bad_pixel_checker;
    import bpc_pkg::*;

    localparam int          IMAGE_WIDTH  = 32;
    localparam int          IMAGE_HEIGHT = 16;
    localparam int          MAX_REGIONS  = 4;
    localparam int          RESET_CYCLES = 8;
    localparam int          DRIVE_DELAY  = 5;     // ns after the rising edge
    localparam logic [31:0] SEED         = 32'd73009;

    // cycle cost of one table load and of one streamed frame
    function automatic int program_cycles(input int count);
        return count + 1;
    endfunction

    function automatic int stream_cycles(input int count);
        return 2 + (2 * count + 1) + IMAGE_HEIGHT * (IMAGE_WIDTH + 2 * count + 3);
    endfunction

    localparam int RUN_CYCLES = RESET_CYCLES + 1
        + program_cycles(3) + 2 * stream_cycles(3)      // idle pass, isolated
        + program_cycles(3) + stream_cycles(3)          // clipping
        + program_cycles(6) + stream_cycles(6)          // overflow
        + program_cycles(20) + 2 * stream_cycles(20);   // random, two frames
    localparam int CYCLE_LIMIT = (RUN_CYCLES * 3) / 2;

    logic                  S_AXI_ACLK;
    logic                  rst_n;
    table_wr_t             table_wr;
    logic [INDEX_BITS-1:0] bad_point_num;
    logic                  frame_start;
    pixel_pos_t            pos;
    logic                  bad_pixel_match;
    logic                  pixel_valid;       // scoreboard qualifier
    int                    check_count;
    int                    error_count;
    int unsigned           cycle_count = 0;
    logic [31:0]           rng_state;
    bad_coord_t            stim_table [TABLE_DEPTH];

    bad_pixel_checker #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .MAX_REGIONS  (MAX_REGIONS)
    ) DUT (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .rst_n           (rst_n),
        .table_wr        (table_wr),
        .bad_point_num   (bad_point_num),
        .frame_start     (frame_start),
        .pos             (pos),
        .bad_pixel_match (bad_pixel_match)
    );

    bpc_scoreboard #(
        .MAX_REGIONS (MAX_REGIONS)
    ) u_scoreboard (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .rst_n           (rst_n),
        .table_wr        (table_wr),
        .bad_point_num   (bad_point_num),
        .frame_start     (frame_start),
        .pos             (pos),
        .pixel_valid     (pixel_valid),
        .bad_pixel_match (bad_pixel_match),
        .check_count     (check_count),
        .error_count     (error_count)
    );

    // builder properties
    bind line_cache_builder bpc_chk #(
        .MAX_REGIONS (MAX_REGIONS)
    ) u_chk (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .rst_n        (rst_n),
        .cache_valid  (cache_valid),
        .region_count (region_count),
        .rd_addr      (rd_addr),
        .entry_count  (entry_count),
        .scan_read    (state == ST_READ)
    );

    // ============================================================
    // clock and run limit
    // ============================================================
    initial begin
        S_AXI_ACLK = 1'b0;
        forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    always @(posedge S_AXI_ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic step();
        @(posedge S_AXI_ACLK);
        #DRIVE_DELAY;
    endtask

    task automatic set_entry(input int idx, input int x, input int y);
        stim_table[idx].x = coord_x_t'(x);
        stim_table[idx].y = coord_y_t'(y);
    endtask

    // one write per cycle, count set first so it settles with the writes
    task automatic program_table(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            step();
            bad_point_num  = INDEX_BITS'(count);
            table_wr.en    = 1'b1;
            table_wr.addr  = INDEX_BITS'(i);
            table_wr.coord = stim_table[i];
        end
        step();
        table_wr.en = 1'b0;
    endtask

    // SOF, build wait, then rows with blanking long enough for each rebuild
    task automatic stream_frame(input int count, input logic with_start);
        int x;
        int y;
        step();
        frame_start = with_start;
        step();
        frame_start = 1'b0;
        repeat (2 * count + 1) step();
        for (y = 0; y < IMAGE_HEIGHT; y++) begin
            for (x = 0; x < IMAGE_WIDTH; x++) begin
                step();
                pos.x       = coord_x_t'(x);
                pos.y       = coord_y_t'(y);
                pixel_valid = 1'b1;
            end
            step();
            pixel_valid = 1'b0;            // last column held during blanking
            repeat (2 * count + 2) step();
        end
    endtask

    task automatic finish_run();
        int assert_fails;
        assert_fails = int'(DUT.u_builder.u_chk.fail_count);
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int i;
        rst_n         = 1'b0;
        table_wr      = '0;
        bad_point_num = '0;
        frame_start   = 1'b0;
        pos           = '0;
        pixel_valid   = 1'b0;
        rng_state     = SEED;
        repeat (RESET_CYCLES) step();
        rst_n = 1'b1;

        // isolated windows, first streamed without any SOF
        set_entry(0, 3, 3);
        set_entry(1, 15, 8);
        set_entry(2, 27, 13);
        program_table(3);
        stream_frame(3, 1'b0);             // must stay low throughout
        stream_frame(3, 1'b1);

        // windows clipped at the low edges
        set_entry(0, 0, 0);
        set_entry(1, 1, 8);
        set_entry(2, 16, 1);
        program_table(3);
        stream_frame(3, 1'b1);

        // six windows in one row band, only four slots
        for (i = 0; i < 6; i++) begin
            set_entry(i, 2 + 5 * i, 7);
        end
        program_table(6);
        stream_frame(6, 1'b1);

        // random table, then a second frame over the same table
        for (i = 0; i < 20; i++) begin
            rng_state = xorshift32(rng_state);
            set_entry(i, int'(rng_state[15:0] % IMAGE_WIDTH),
                      int'(rng_state[31:16] % IMAGE_HEIGHT));
        end
        program_table(20);
        stream_frame(20, 1'b1);
        stream_frame(20, 1'b1);

        step();
        finish_run();
    end

endmodule

//--- build.f
src/bpc_pkg.sv
src/coord_table.sv
src/line_cache_builder.sv
src/region_matcher.sv
src/bad_pixel_checker.sv
test/bpc_chk.sv
test/bpc_scoreboard.sv
test/tb_bad_pixel_checker.sv

//--- Makefile
# Verilator build and run for the bad-pixel checker

VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_bad_pixel_checker
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
